// File: Makefile
SIM          = verilator
SIM_FLAGS    = --binary --timing --assert -Wno-fatal
TOP          = tb_vertex_job_control
FILE_LIST    = sources.f
BUILD_DIR    = obj_dir
RUN_FLAGS    = +verilator+error+limit+1000
PASS_MESSAGE = Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@output="$$($(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/tb_clock_gen.sv
// Clock and reset source of the testbench.
// rstn is low for reset_cycles rising edges and is released on an edge.
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int period       = 20,
	parameter int reset_cycles = 4
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(period / 2) clock = ~clock;
	end

	initial begin
		rstn = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

`default_nettype wire

// File: dv/tb_vertex_job_control.sv
// Testbench of the vertex job fetcher.
// Runs several starts with LFSR-chosen counts and bases, answers reads from
// a pattern memory and pops jobs with random pauses.
// Grants and pops are single-cycle pulses with at least one idle cycle between.
// The bound checker compares the values; this module counts timeouts.
`timescale 1ns/100ps
`default_nettype none

module tb_vertex_job_control;

	localparam int run_count  = 8;
	localparam int wait_limit = 20000;

	logic                          clock;
	logic                          rstn;
	logic                          start;
	vertex_job_pkg::vertex_count_t num_vertices;
	vertex_job_pkg::addr_t         out_degree_base;
	vertex_job_pkg::addr_t         edges_idx_base;
	vertex_job_pkg::vertex_count_t id_base;
	logic                          read_command_grant  = 1'b0;
	logic                          read_data_valid     = 1'b0;
	vertex_job_pkg::array_sel_t    read_data_array     = vertex_job_pkg::inv_out_degree;
	vertex_job_pkg::line_t         read_data_line      = '0;
	logic                          read_response_valid = 1'b0;
	vertex_job_pkg::array_sel_t    read_response_array = vertex_job_pkg::inv_out_degree;
	logic                          vertex_request      = 1'b0;
	logic                          busy;
	logic                          read_command_request;
	vertex_job_pkg::read_cmd_t     read_command;
	logic                          vertex_job_available;
	vertex_job_pkg::vertex_job_t   vertex_job;

	// chosen at the falling edge, driven at the next rising edge
	logic                          next_grant          = 1'b0;
	logic                          next_request        = 1'b0;
	logic                          next_data_valid     = 1'b0;
	vertex_job_pkg::array_sel_t    next_data_array     = vertex_job_pkg::inv_out_degree;
	vertex_job_pkg::line_t         next_data_line      = '0;
	logic                          next_response_valid = 1'b0;
	vertex_job_pkg::array_sel_t    next_response_array = vertex_job_pkg::inv_out_degree;

	vertex_job_pkg::read_cmd_t     pending_reads[$];
	vertex_job_pkg::array_sel_t    pending_responses[$];
	logic [15:0]                   lfsr           = 16'd28548;
	int                            popped         = 0;
	int                            check_errors   = 0;
	int                            timeout_errors = 0;
	string                         test_name      = "reset";

	tb_clock_gen u_clock_gen (
		.clock (clock),
		.rstn  (rstn)
	);

	vertex_job_control #(
		.cmd_depth (16),
		.job_depth (64)
	) u_dut (
		.clock                (clock),
		.rstn                 (rstn),
		.start                (start),
		.num_vertices         (num_vertices),
		.out_degree_base      (out_degree_base),
		.edges_idx_base       (edges_idx_base),
		.id_base              (id_base),
		.read_command_grant   (read_command_grant),
		.read_data_valid      (read_data_valid),
		.read_data_array      (read_data_array),
		.read_data_line       (read_data_line),
		.read_response_valid  (read_response_valid),
		.read_response_array  (read_response_array),
		.vertex_request       (vertex_request),
		.busy                 (busy),
		.read_command_request (read_command_request),
		.read_command         (read_command),
		.vertex_job_available (vertex_job_available),
		.vertex_job           (vertex_job)
	);

	bind vertex_job_control vertex_job_control_sva u_sva (
		.clock                (clock),
		.rstn                 (rstn),
		.start                (start),
		.busy                 (busy),
		.num_vertices         (num_vertices),
		.out_degree_base      (out_degree_base),
		.edges_idx_base       (edges_idx_base),
		.id_base              (id_base),
		.read_command_request (read_command_request),
		.read_command_grant   (read_command_grant),
		.read_command         (read_command),
		.vertex_job_available (vertex_job_available),
		.vertex_request       (vertex_request),
		.vertex_job           (vertex_job),
		.job_push             (job_push),
		.job_free             (job_free)
	);

	//////////////////////////////
	// helpers
	//////////////////////////////

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic        feedback;
		value = '0;
		for (int i = 0; i < n; i++) begin
			feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr     = {lfsr[14:0], feedback};
			value    = {value[30:0], feedback};
		end
		return value;
	endfunction

	// pattern memory: slot k holds the tag plus the vertex index of the run
	function automatic vertex_job_pkg::line_t make_line(input vertex_job_pkg::read_cmd_t cmd);
		vertex_job_pkg::line_t         line;
		vertex_job_pkg::addr_t         offset;
		vertex_job_pkg::vertex_word_t  tag;
		vertex_job_pkg::vertex_count_t first;
		if (cmd.array == vertex_job_pkg::inv_out_degree) begin
			offset = cmd.address - out_degree_base;
			tag    = 32'h1000_0000;
		end else begin
			offset = cmd.address - edges_idx_base;
			tag    = 32'h2000_0000;
		end
		first = vertex_job_pkg::vertex_count_t'(offset >> 7) * 32;
		for (int k = 0; k < 32; k++)
			line[32*k +: 32] = tag + first + k;
		return line;
	endfunction

	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		while (!rstn && cycles < 100) begin
			@(negedge clock);
			cycles++;
		end
		if (!rstn) begin
			timeout_errors++;
			$display("Timeout: reset was never released");
		end
	endtask

	task automatic wait_until_idle();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (busy && cycles < wait_limit) begin
			@(negedge clock);
			cycles++;
		end
		if (busy) begin
			timeout_errors++;
			$display("Timeout: %s, the fetcher stayed busy before the next start", test_name);
		end
	endtask

	task automatic wait_for_jobs(input int expected);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while ((popped != expected || busy) && cycles < wait_limit) begin
			@(negedge clock);
			cycles++;
		end
		if (popped != expected || busy) begin
			timeout_errors++;
			$display("Timeout: %s, jobs popped %0d of %0d, busy %b",
				test_name, popped, expected, busy);
		end
	endtask

	//////////////////////////////
	// stimulus
	//////////////////////////////

	initial begin : stimulus
		vertex_job_pkg::vertex_count_t counts [run_count];
		int                            first_pop;
		start           = 1'b0;
		num_vertices    = '0;
		out_degree_base = '0;
		edges_idx_base  = '0;
		id_base         = '0;
		counts          = '{1, 32, 33, 100, 0, 0, 0, 0};
		for (int r = 5; r < run_count; r++)
			counts[r] = 1 + rand_bits(7) % 100;
		wait_for_reset();
		// quiet stretch so the outputs are seen low before any start
		repeat (5) @(posedge clock);
		for (int r = 0; r < run_count; r++) begin
			wait_until_idle();
			@(posedge clock);
			test_name = $sformatf("run%0d_n%0d", r, counts[r]);
			first_pop = popped;
			start           <= 1'b1;
			num_vertices    <= counts[r];
			out_degree_base <= vertex_job_pkg::addr_t'(rand_bits(28)) << 7;
			edges_idx_base  <= vertex_job_pkg::addr_t'(rand_bits(28)) << 7;
			id_base         <= rand_bits(32);
			@(posedge clock);
			start <= 1'b0;
			wait_for_jobs(first_pop + counts[r]);
		end
		$display("Closing: %0d assertion failures, %0d timeouts", check_errors, timeout_errors);
		if (check_errors == 0 && timeout_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// bus, memory responder and consumer choices on stable outputs
	always @(negedge clock) begin : respond_and_consume
		vertex_job_pkg::read_cmd_t cmd;
		int                        pick;
		next_grant          = 1'b0;
		next_request        = 1'b0;
		next_data_valid     = 1'b0;
		next_response_valid = 1'b0;
		if (rstn) begin
			if (read_command_grant && read_command_request)
				pending_reads.push_back(read_command);
			next_grant   = read_command_request && !read_command_grant && rand_bits(2) != 0;
			next_request = vertex_job_available && !vertex_request && rand_bits(2) != 0;
			if (pending_reads.size() > 0 && rand_bits(1)) begin
				pick = (pending_reads.size() > 1) ? int'(rand_bits(1)) : 0;
				cmd  = pending_reads[pick];
				pending_reads.delete(pick);
				next_data_valid = 1'b1;
				next_data_array = cmd.array;
				next_data_line  = make_line(cmd);
				// response with the data, or held for later
				if (rand_bits(1)) begin
					next_response_valid = 1'b1;
					next_response_array = cmd.array;
				end else begin
					pending_responses.push_back(cmd.array);
				end
			end else if (pending_responses.size() > 0 && rand_bits(1)) begin
				pick = (pending_responses.size() > 1) ? int'(rand_bits(1)) : 0;
				next_response_valid = 1'b1;
				next_response_array = pending_responses[pick];
				pending_responses.delete(pick);
			end
		end
	end

	always @(posedge clock) begin : drive_inputs
		read_command_grant  <= next_grant;
		vertex_request      <= next_request;
		read_data_valid     <= next_data_valid;
		read_data_array     <= next_data_array;
		read_data_line      <= next_data_line;
		read_response_valid <= next_response_valid;
		read_response_array <= next_response_array;
		// each request pulse is a pop, since availability was checked
		if (vertex_request)
			popped <= popped + 1;
	end

endmodule

`default_nettype wire

// File: dv/vertex_job_control_sva.sv
// Checker bound into the vertex job fetcher.
// Expected values follow from the start arguments and the counts of grants,
// pops and pushes. The job words assume the testbench memory pattern of
// 0x1000_0000 or 0x2000_0000 plus the vertex index of the run.
// Each failure also adds to the testbench error counter.
`timescale 1ns/100ps
`default_nettype none

module vertex_job_control_sva (
	input wire logic                          clock,
	input wire logic                          rstn,
	input wire logic                          start,
	input wire logic                          busy,
	input wire vertex_job_pkg::vertex_count_t num_vertices,
	input wire vertex_job_pkg::addr_t         out_degree_base,
	input wire vertex_job_pkg::addr_t         edges_idx_base,
	input wire vertex_job_pkg::vertex_count_t id_base,
	input wire logic                          read_command_request,
	input wire logic                          read_command_grant,
	input wire vertex_job_pkg::read_cmd_t     read_command,
	input wire logic                          vertex_job_available,
	input wire logic                          vertex_request,
	input wire vertex_job_pkg::vertex_job_t   vertex_job,
	input wire logic                          job_push,
	input wire vertex_job_pkg::vertex_count_t job_free
);

	logic                          started;
	logic                          accept;
	logic                          grant_fire;
	logic                          pop_fire;
	vertex_job_pkg::vertex_count_t exp_num;
	vertex_job_pkg::vertex_count_t first_id;
	vertex_job_pkg::addr_t         degree_base;
	vertex_job_pkg::addr_t         idx_base;
	vertex_job_pkg::vertex_count_t grant_count;
	vertex_job_pkg::vertex_count_t pop_count;
	vertex_job_pkg::vertex_count_t push_count;
	vertex_job_pkg::vertex_count_t chunk;
	vertex_job_pkg::vertex_count_t remaining;
	logic [5:0]                    exp_real;
	logic                          exp_array;
	vertex_job_pkg::addr_t         exp_address;
	logic [95:0]                   exp_job;

	// smallest power of two bytes that holds n words of 4 bytes, at least 4
	function automatic logic [7:0] padded_bytes(input logic [5:0] n);
		int bytes;
		bytes = int'(n) * 4;
		if (bytes <= 4)
			return 8'd4;
		else if (bytes <= 8)
			return 8'd8;
		else if (bytes <= 16)
			return 8'd16;
		else if (bytes <= 32)
			return 8'd32;
		else if (bytes <= 64)
			return 8'd64;
		else
			return 8'd128;
	endfunction

	//////////////////////////////
	// tracking
	//////////////////////////////

	assign accept     = start && !busy;
	assign grant_fire = read_command_request && read_command_grant;
	assign pop_fire   = vertex_job_available && vertex_request;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			started     <= 1'b0;
			exp_num     <= '0;
			first_id    <= '0;
			degree_base <= '0;
			idx_base    <= '0;
			grant_count <= '0;
			pop_count   <= '0;
			push_count  <= '0;
		end else if (accept) begin
			started     <= 1'b1;
			exp_num     <= num_vertices;
			first_id    <= id_base;
			degree_base <= out_degree_base;
			idx_base    <= edges_idx_base;
			grant_count <= '0;
			pop_count   <= '0;
			push_count  <= '0;
		end else begin
			if (grant_fire)
				grant_count <= grant_count + 1;
			if (pop_fire)
				pop_count <= pop_count + 1;
			if (job_push)
				push_count <= push_count + 1;
		end
	end

	// two commands per chunk, degree array first; 32 vertices per 128-byte line
	assign chunk       = grant_count >> 1;
	assign remaining   = exp_num - chunk * 32;
	assign exp_real    = (remaining > 32) ? 6'd32 : remaining[5:0];
	assign exp_array   = grant_count[0];
	assign exp_address = (grant_count[0] ? idx_base : degree_base)
		+ (vertex_job_pkg::addr_t'(chunk) << 7);
	assign exp_job     = {first_id + pop_count, 32'h1000_0000 + pop_count,
		32'h2000_0000 + pop_count};

	//////////////////////////////
	// assertions
	//////////////////////////////

	idle_after_reset: assert property (@(posedge clock) disable iff (!rstn)
		!started |-> !busy && !read_command_request && !vertex_job_available)
	else begin
		$error("Mismatch %s idle_after_reset: expected 000 actual %b%b%b",
			tb_vertex_job_control.test_name, $sampled(busy),
			$sampled(read_command_request), $sampled(vertex_job_available));
		tb_vertex_job_control.check_errors++;
	end

	cmd_target: assert property (@(posedge clock) disable iff (!rstn)
		grant_fire |-> read_command.array == vertex_job_pkg::array_sel_t'(exp_array)
			&& read_command.address == exp_address)
	else begin
		$error("Mismatch %s cmd_target: expected %0d:%h actual %0d:%h",
			tb_vertex_job_control.test_name, $sampled(exp_array), $sampled(exp_address),
			$sampled(read_command.array), $sampled(read_command.address));
		tb_vertex_job_control.check_errors++;
	end

	cmd_size: assert property (@(posedge clock) disable iff (!rstn)
		grant_fire |-> read_command.real_size == exp_real
			&& read_command.size_bytes == padded_bytes(exp_real))
	else begin
		$error("Mismatch %s cmd_size: expected %0d/%0d actual %0d/%0d",
			tb_vertex_job_control.test_name, $sampled(exp_real),
			padded_bytes($sampled(exp_real)), $sampled(read_command.real_size),
			$sampled(read_command.size_bytes));
		tb_vertex_job_control.check_errors++;
	end

	job_fields: assert property (@(posedge clock) disable iff (!rstn)
		pop_fire |-> vertex_job == exp_job)
	else begin
		$error("Mismatch %s job_fields: expected %h actual %h",
			tb_vertex_job_control.test_name, $sampled(exp_job), $sampled(vertex_job));
		tb_vertex_job_control.check_errors++;
	end

	job_total: assert property (@(posedge clock) disable iff (!rstn)
		$fell(busy) |-> push_count == exp_num)
	else begin
		$error("Mismatch %s job_total: expected %0d actual %0d",
			tb_vertex_job_control.test_name, $sampled(exp_num), $sampled(push_count));
		tb_vertex_job_control.check_errors++;
	end

	job_excess: assert property (@(posedge clock) disable iff (!rstn)
		job_push |-> push_count < exp_num)
	else begin
		$error("%s: a job was queued beyond the %0d vertices requested",
			tb_vertex_job_control.test_name, $sampled(exp_num));
		tb_vertex_job_control.check_errors++;
	end

	// the first command of a chunk shows up as a rising request
	chunk_room: assert property (@(posedge clock) disable iff (!rstn)
		$rose(read_command_request) |-> job_free >= 32)
	else begin
		$error("%s: a chunk started with only %0d free job places",
			tb_vertex_job_control.test_name, $sampled(job_free));
		tb_vertex_job_control.check_errors++;
	end

endmodule

`default_nettype wire

// File: rtl/job_queue.sv
// First-word-fall-through queue on a register array.
// The head shows the oldest entry; a push appears there one cycle later.
// A push when full or a pop when empty is dropped without notice.
// depth must be at least 2.
`timescale 1ns/100ps
`default_nettype none

module job_queue #(
	parameter type payload_t = logic [31:0],
	parameter int  depth     = 16
) (
	input  wire logic                          clock,
	input  wire logic                          rstn,
	input  wire logic                          push,
	input  wire payload_t                      push_data,
	input  wire logic                          pop,
	output payload_t                           head,
	output logic                               not_empty,
	output vertex_job_pkg::vertex_count_t      free_count
);

	localparam int ptr_w   = $clog2(depth);
	localparam int count_w = $clog2(depth + 1);

	payload_t           mem [depth];
	logic [ptr_w-1:0]   rd_ptr;
	logic [ptr_w-1:0]   wr_ptr;
	logic [count_w-1:0] count;
	logic               do_push;
	logic               do_pop;

	assign do_push    = push && (count != count_w'(depth));
	assign do_pop     = pop && (count != '0);
	assign not_empty  = (count != '0);
	assign head       = mem[rd_ptr];
	assign free_count = vertex_job_pkg::vertex_count_t'(depth)
		- vertex_job_pkg::vertex_count_t'(count);

	// storage
	always_ff @(posedge clock) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	// pointers wrap at depth, which need not be a power of two
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/read_command_gen.sv
// Remaining-vertex counter and read command builder.
// The command shows the degree array except while push_idx_cmd is high.
// A new chunk is settled one cycle after step_chunk.
`timescale 1ns/100ps
`default_nettype none

module read_command_gen (
	input  wire logic                          clock,
	input  wire logic                          rstn,
	input  wire logic                          load_count,
	input  wire logic                          step_chunk,
	input  wire logic                          push_idx_cmd,
	input  wire vertex_job_pkg::vertex_count_t num_vertices,
	input  wire vertex_job_pkg::addr_t         out_degree_base,
	input  wire vertex_job_pkg::addr_t         edges_idx_base,
	output logic                               remaining_zero,
	output vertex_job_pkg::vertex_count_t      chunk_size,
	output vertex_job_pkg::read_cmd_t          command
);

	vertex_job_pkg::addr_t         degree_base;
	vertex_job_pkg::addr_t         idx_base;
	vertex_job_pkg::addr_t         line_offset;
	vertex_job_pkg::vertex_count_t remaining;
	logic [5:0]                    chunk_real;
	logic [7:0]                    chunk_bytes;
	logic [5:0]                    step_real;

	// a full line, or whatever is left
	assign step_real = (remaining > vertex_job_pkg::vertex_count_t'(
		vertex_job_pkg::vertices_per_line))
		? 6'(vertex_job_pkg::vertices_per_line) : remaining[5:0];

	assign remaining_zero = (remaining == '0);
	assign chunk_size     = vertex_job_pkg::vertex_count_t'(chunk_real);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining   <= '0;
			line_offset <= '0;
		end else if (load_count) begin
			remaining   <= num_vertices;
			line_offset <= '0;
		end else begin
			if (step_chunk)
				remaining <= remaining - vertex_job_pkg::vertex_count_t'(step_real);
			// next line once both arrays of this chunk are queued
			if (push_idx_cmd)
				line_offset <= line_offset
					+ vertex_job_pkg::addr_t'(vertex_job_pkg::line_bytes);
		end
	end

	always_ff @(posedge clock) begin
		if (load_count) begin
			degree_base <= out_degree_base;
			idx_base    <= edges_idx_base;
		end
		if (step_chunk) begin
			chunk_real  <= step_real;
			chunk_bytes <= vertex_job_pkg::request_size(step_real);
		end
	end

	always_comb begin
		command.address    = (push_idx_cmd ? idx_base : degree_base) + line_offset;
		command.array      = push_idx_cmd ? vertex_job_pkg::inv_edges_idx
			: vertex_job_pkg::inv_out_degree;
		command.real_size  = chunk_real;
		command.size_bytes = chunk_bytes;
	end

endmodule

`default_nettype wire

// File: rtl/vertex_fetch_control.sv
// Chunk sequencer of the vertex job fetcher.
// A chunk starts only with an empty command queue and at least one
// line of free job slots. busy is high from accept until the last push.
`timescale 1ns/100ps
`default_nettype none

module vertex_fetch_control (
	input  wire logic                          clock,
	input  wire logic                          rstn,
	input  wire logic                          start,
	input  wire logic                          remaining_zero,
	input  wire vertex_job_pkg::vertex_count_t chunk_size,
	input  wire logic                          cmd_queue_empty,
	input  wire vertex_job_pkg::vertex_count_t job_free,
	input  wire logic                          line_pair_ready,
	output logic                               busy,
	output logic                               load_count,
	output logic                               step_chunk,
	output logic                               push_degree_cmd,
	output logic                               push_idx_cmd,
	output logic                               clear_ready,
	output logic                               shift_en
);

	typedef enum logic [2:0] {
		s_idle,
		s_load,
		s_check_room,
		s_step,
		s_send_degree,
		s_send_idx,
		s_wait_data,
		s_shift
	} state_t;

	state_t                        state;
	state_t                        next_state;
	vertex_job_pkg::vertex_count_t shift_count;
	logic                          room_ok;
	logic                          last_shift;

	assign room_ok    = cmd_queue_empty
		&& (job_free >= vertex_job_pkg::vertex_count_t'(vertex_job_pkg::vertices_per_line));
	assign last_shift = (shift_count == chunk_size - 1'b1);

	// strobes decoded from the state
	assign busy            = (state != s_idle);
	assign load_count      = (state == s_idle) && start;
	assign step_chunk      = (state == s_step);
	assign push_degree_cmd = (state == s_send_degree);
	assign push_idx_cmd    = (state == s_send_idx);
	assign clear_ready     = (state == s_wait_data) && line_pair_ready;
	assign shift_en        = (state == s_shift);

	always_comb begin
		next_state = state;
		case (state)
			s_idle:        if (start) next_state = s_load;
			s_load:        next_state = s_check_room;
			s_check_room: begin
				if (remaining_zero)
					next_state = s_idle;
				else if (room_ok)
					next_state = s_step;
			end
			s_step:        next_state = s_send_degree;
			s_send_degree: next_state = s_send_idx;
			s_send_idx:    next_state = s_wait_data;
			s_wait_data:   if (line_pair_ready) next_state = s_shift;
			// skip the room check after the last chunk so busy drops at once
			s_shift: begin
				if (last_shift)
					next_state = remaining_zero ? s_idle : s_check_room;
			end
			default:       next_state = s_idle;
		endcase
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state       <= s_idle;
			shift_count <= '0;
		end else begin
			state <= next_state;
			if (state == s_shift && !last_shift)
				shift_count <= shift_count + 1'b1;
			else
				shift_count <= '0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/vertex_job_control.sv
// Vertex job fetcher top level.
// start is taken only while busy is low; a count of zero yields no jobs.
// job_depth must be at least vertices_per_line, cmd_depth at least 2.
// A grant or a vertex_request is honoured only while its level is high.
`timescale 1ns/100ps
`default_nettype none

module vertex_job_control #(
	parameter int cmd_depth = 16,
	parameter int job_depth = 64
) (
	input  wire logic                          clock,
	input  wire logic                          rstn,
	input  wire logic                          start,
	input  wire vertex_job_pkg::vertex_count_t num_vertices,
	input  wire vertex_job_pkg::addr_t         out_degree_base,
	input  wire vertex_job_pkg::addr_t         edges_idx_base,
	input  wire vertex_job_pkg::vertex_count_t id_base,
	input  wire logic                          read_command_grant,
	input  wire logic                          read_data_valid,
	input  wire vertex_job_pkg::array_sel_t    read_data_array,
	input  wire vertex_job_pkg::line_t         read_data_line,
	input  wire logic                          read_response_valid,
	input  wire vertex_job_pkg::array_sel_t    read_response_array,
	input  wire logic                          vertex_request,
	output logic                               busy,
	output logic                               read_command_request,
	output vertex_job_pkg::read_cmd_t          read_command,
	output logic                               vertex_job_available,
	output vertex_job_pkg::vertex_job_t        vertex_job
);

	logic                          load_count;
	logic                          step_chunk;
	logic                          push_degree_cmd;
	logic                          push_idx_cmd;
	logic                          clear_ready;
	logic                          shift_en;
	logic                          remaining_zero;
	logic                          line_pair_ready;
	logic                          job_push;
	vertex_job_pkg::vertex_count_t chunk_size;
	vertex_job_pkg::vertex_count_t job_free;
	vertex_job_pkg::read_cmd_t     command;
	vertex_job_pkg::vertex_job_t   job_data;

	vertex_fetch_control u_fetch_control (
		.clock           (clock),
		.rstn            (rstn),
		.start           (start),
		.remaining_zero  (remaining_zero),
		.chunk_size      (chunk_size),
		.cmd_queue_empty (!read_command_request),
		.job_free        (job_free),
		.line_pair_ready (line_pair_ready),
		.busy            (busy),
		.load_count      (load_count),
		.step_chunk      (step_chunk),
		.push_degree_cmd (push_degree_cmd),
		.push_idx_cmd    (push_idx_cmd),
		.clear_ready     (clear_ready),
		.shift_en        (shift_en)
	);

	read_command_gen u_command_gen (
		.clock           (clock),
		.rstn            (rstn),
		.load_count      (load_count),
		.step_chunk      (step_chunk),
		.push_idx_cmd    (push_idx_cmd),
		.num_vertices    (num_vertices),
		.out_degree_base (out_degree_base),
		.edges_idx_base  (edges_idx_base),
		.remaining_zero  (remaining_zero),
		.chunk_size      (chunk_size),
		.command         (command)
	);

	// the accept pulse restarts the id counter
	vertex_line_unpack u_line_unpack (
		.clock               (clock),
		.rstn                (rstn),
		.start               (load_count),
		.id_base             (id_base),
		.read_data_valid     (read_data_valid),
		.read_data_array     (read_data_array),
		.read_data_line      (read_data_line),
		.read_response_valid (read_response_valid),
		.read_response_array (read_response_array),
		.clear_ready         (clear_ready),
		.shift_en            (shift_en),
		.line_pair_ready     (line_pair_ready),
		.job_push            (job_push),
		.job_data            (job_data)
	);

	job_queue #(
		.payload_t (vertex_job_pkg::read_cmd_t),
		.depth     (cmd_depth)
	) u_cmd_queue (
		.clock      (clock),
		.rstn       (rstn),
		.push       (push_degree_cmd || push_idx_cmd),
		.push_data  (command),
		.pop        (read_command_grant),
		.head       (read_command),
		.not_empty  (read_command_request),
		.free_count ()
	);

	job_queue #(
		.payload_t (vertex_job_pkg::vertex_job_t),
		.depth     (job_depth)
	) u_job_queue (
		.clock      (clock),
		.rstn       (rstn),
		.push       (job_push),
		.push_data  (job_data),
		.pop        (vertex_request),
		.head       (vertex_job),
		.not_empty  (vertex_job_available),
		.free_count (job_free)
	);

endmodule

`default_nettype wire

// File: rtl/vertex_job_pkg.sv
// Shared widths and types of the vertex job fetcher.
// A line holds 32 elements of 4 bytes, with slot 0 in the lowest bits.
// request_size assumes real_size is at most vertices_per_line.
`default_nettype none

package vertex_job_pkg;

	localparam int line_bytes        = 128;
	localparam int vertex_bytes      = 4;
	localparam int vertices_per_line = line_bytes / vertex_bytes;

	typedef logic [63:0]   addr_t;
	typedef logic [31:0]   vertex_word_t;
	typedef logic [31:0]   vertex_count_t;
	typedef logic [1023:0] line_t;

	typedef enum logic {
		inv_out_degree,
		inv_edges_idx
	} array_sel_t;

	typedef struct packed {
		addr_t      address;
		array_sel_t array;
		logic [5:0] real_size;
		logic [7:0] size_bytes;
	} read_cmd_t;

	typedef struct packed {
		vertex_count_t id;
		vertex_word_t  inverse_out_degree;
		vertex_word_t  inverse_edges_idx;
	} vertex_job_t;

	// bytes of the chunk, rounded up to a power of two, at least 4
	function automatic logic [7:0] request_size(input logic [5:0] real_size);
		logic [8:0] bytes;
		logic [7:0] size;
		bytes = 9'(real_size) * 9'(vertex_bytes);
		size  = 8'd4;
		for (int i = 0; i < 5; i++) begin
			if ({1'b0, size} < bytes)
				size = size << 1;
		end
		return size;
	endfunction

endpackage

`default_nettype wire

// File: rtl/vertex_line_unpack.sv
// Line capture and vertex shifter.
// Data for an array must come no later than its response.
// Both lines move down one slot per shift_en cycle; slot 0 forms the job.
`timescale 1ns/100ps
`default_nettype none

module vertex_line_unpack (
	input  wire logic                          clock,
	input  wire logic                          rstn,
	input  wire logic                          start,
	input  wire vertex_job_pkg::vertex_count_t id_base,
	input  wire logic                          read_data_valid,
	input  wire vertex_job_pkg::array_sel_t    read_data_array,
	input  wire vertex_job_pkg::line_t         read_data_line,
	input  wire logic                          read_response_valid,
	input  wire vertex_job_pkg::array_sel_t    read_response_array,
	input  wire logic                          clear_ready,
	input  wire logic                          shift_en,
	output logic                               line_pair_ready,
	output logic                               job_push,
	output vertex_job_pkg::vertex_job_t        job_data
);

	localparam int word_w = $bits(vertex_job_pkg::vertex_word_t);

	vertex_job_pkg::line_t         degree_line;
	vertex_job_pkg::line_t         idx_line;
	logic                          degree_arrived;
	logic                          idx_arrived;
	vertex_job_pkg::vertex_count_t next_id;

	//////////////////////////////
	// line registers
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (read_data_valid) begin
			if (read_data_array == vertex_job_pkg::inv_out_degree)
				degree_line <= read_data_line;
			else
				idx_line <= read_data_line;
		end else if (shift_en) begin
			degree_line <= degree_line >> word_w;
			idx_line    <= idx_line >> word_w;
		end
	end

	// arrival flags, cleared when the pair is taken
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			degree_arrived <= 1'b0;
			idx_arrived    <= 1'b0;
		end else begin
			if (clear_ready) begin
				degree_arrived <= 1'b0;
				idx_arrived    <= 1'b0;
			end
			if (read_response_valid) begin
				if (read_response_array == vertex_job_pkg::inv_out_degree)
					degree_arrived <= 1'b1;
				else
					idx_arrived <= 1'b1;
			end
		end
	end

	assign line_pair_ready = degree_arrived && idx_arrived;

	//////////////////////////////
	// job forming
	//////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			next_id <= '0;
		else if (start)
			next_id <= id_base;
		else if (shift_en)
			next_id <= next_id + 1'b1;
	end

	assign job_push = shift_en;

	always_comb begin
		job_data.id                 = next_id;
		job_data.inverse_out_degree = degree_line[word_w-1:0];
		job_data.inverse_edges_idx  = idx_line[word_w-1:0];
	end

endmodule

`default_nettype wire

// File: sources.f
rtl/vertex_job_pkg.sv
rtl/job_queue.sv
rtl/vertex_fetch_control.sv
rtl/read_command_gen.sv
rtl/vertex_line_unpack.sv
rtl/vertex_job_control.sv
dv/tb_clock_gen.sv
dv/vertex_job_control_sva.sv
dv/tb_vertex_job_control.sv
